/* rtl/hispi_cfg.svh */
// receiver configuration for a 4-lane HiSPi sensor, Packetized-SP, 10-bit pixels
// the window and run lengths only suit 10-bit pixels from an 8-bit deserializer
`ifndef HISPI_CFG_SVH
`define HISPI_CFG_SVH

// ----------------------------------------
// lane and word geometry
// ----------------------------------------
`define HISPI_LANES       4   // data lanes from the sensor
`define HISPI_BYTE_W      8   // deserializer output width
`define HISPI_PIX_W       10  // one pixel per lane word

// ----------------------------------------
// sync search
// ----------------------------------------
// window of five words, 50 bits, wide enough to hold the zero run at any phase
`define HISPI_WIN_WORDS   5
// two all-zero words of the sync header, 3FF 000 000 code
`define HISPI_SYNC_ZEROS  20

// ----------------------------------------
// reset
// ----------------------------------------
// cycles px_reset stays high once idelay_rdy has passed the synchronizer
`define HISPI_RST_HOLD    32

`endif

/* rtl/hispi_pkg.sv */
// shared types for the HiSPi pixel receiver
// lane 0 sits in the low slice of every per-lane bus
package hispi_pkg;

  `include "hispi_cfg.svh"

  // ----------------------------------------
  // per-lane buses
  // ----------------------------------------
  typedef struct packed {
    logic [`HISPI_LANES-1:0][`HISPI_BYTE_W-1:0] lane;  // first received bit in bit 7
  } lane_bytes_t;

  typedef struct packed {
    logic [`HISPI_LANES-1:0][`HISPI_PIX_W-1:0] lane;   // first received bit in bit 9
  } lane_words_t;

  // one-cycle pulses from the sync decoder
  typedef struct packed {
    logic sof;
    logic sol;
    logic eol;
    logic eof;
    logic error;
  } sync_flags_t;

  // ----------------------------------------
  // sync code word
  // ----------------------------------------
  localparam int CODE_W = 3;  // code field sits in the last received bits

  localparam logic [CODE_W-1:0] CODE_SOL = 3'b001;
  localparam logic [CODE_W-1:0] CODE_SOF = 3'b011;
  localparam logic [CODE_W-1:0] CODE_EOL = 3'b101;
  localparam logic [CODE_W-1:0] CODE_EOF = 3'b111;

  // 4th header word, seen raw for debug or split for decode
  typedef union packed {
    logic [`HISPI_PIX_W-1:0] raw;
    struct packed {
      logic [`HISPI_PIX_W-CODE_W-1:0] hdr;   // upper bits, ignored by decode
      logic [CODE_W-1:0]              code;
    } fld;
  } sync_word_u;

  // width of the reset hold counter
  localparam int RST_CNT_W = $clog2(`HISPI_RST_HOLD + 1);

endpackage

/* rtl/phy_reset_seq.sv */
// idelay_rdy is async, active low; px_reset leaves reset HISPI_RST_HOLD + 2 clocks
// after idelay_rdy rises
`timescale 1ns/1ps
`include "hispi_cfg.svh"

module phy_reset_seq
  import hispi_pkg::*;
(
  input  logic clk_out_pix,
  input  logic idelay_rdy,
  output logic px_reset,        // internal reset, active high
  output logic reset_sync_out   // same level, for the image pipeline
);

  logic [1:0]           rdy_sync;  // two-flop synchronizer on the release edge
  logic [RST_CNT_W-1:0] hold_cnt;  // counts down once the release is synced

  always_ff @(posedge clk_out_pix or negedge idelay_rdy) begin
    if (!idelay_rdy) begin
      rdy_sync <= '0;
      hold_cnt <= RST_CNT_W'(`HISPI_RST_HOLD);
      px_reset <= 1'b1;
    end else begin
      rdy_sync <= {rdy_sync[0], 1'b1};
      if (!rdy_sync[1]) begin
        // release not through the synchronizer yet
        hold_cnt <= RST_CNT_W'(`HISPI_RST_HOLD);
        px_reset <= 1'b1;
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
        px_reset <= (hold_cnt > RST_CNT_W'(1));  // drops on the last count
      end
    end
  end

  assign reset_sync_out = px_reset;

endmodule

/* rtl/gearbox_8to10.sv */
// 8:10 gearbox, all lanes strobe together so one fill count serves every lane
// no back-pressure; a word appears one clock after the byte that completes it
`timescale 1ns/1ps
`include "hispi_cfg.svh"

module gearbox_8to10
  import hispi_pkg::*;
(
  input  logic        clk_out_pix,
  input  logic        idelay_rdy,
  input  logic        px_reset,
  input  logic        byte_valid,
  input  lane_bytes_t byte_data,
  output logic        word_valid,
  output lane_words_t word_data
);

  localparam int PIX_W  = `HISPI_PIX_W;
  localparam int BYTE_W = `HISPI_BYTE_W;
  localparam int ACC_W  = PIX_W + BYTE_W - 1;  // at most 9 left over plus a new byte
  localparam int FILL_W = $clog2(ACC_W + 1);

  logic [ACC_W-1:0]  acc      [`HISPI_LANES];  // unsent bits, oldest at the top
  logic [ACC_W-1:0]  acc_next [`HISPI_LANES];
  logic [FILL_W-1:0] fill;                      // valid bits in acc, shared by lanes
  logic [FILL_W-1:0] fill_app;                  // fill once the new byte is in
  logic [FILL_W-1:0] fill_next;
  logic [FILL_W-1:0] shamt;                     // bits newer than the outgoing word
  logic              emit;
  lane_words_t       word_next;

  // ----------------------------------------
  // append and extract
  // ----------------------------------------
  always_comb begin
    fill_app  = fill + FILL_W'(BYTE_W);
    emit      = (fill_app >= FILL_W'(PIX_W));
    fill_next = emit ? fill_app - FILL_W'(PIX_W) : fill_app;
    shamt     = emit ? fill_app - FILL_W'(PIX_W) : '0;
    for (int l = 0; l < `HISPI_LANES; l++) begin
      // byte bit 7 arrived first, so it lands just behind the older bits
      acc_next[l] = {acc[l][ACC_W-BYTE_W-1:0], byte_data.lane[l]};
      // oldest ten bits, first received ends up in bit 9
      word_next.lane[l] = PIX_W'(acc_next[l] >> shamt);
    end
  end

  // ----------------------------------------
  // bit store
  // ----------------------------------------
  always_ff @(posedge clk_out_pix) begin
    if (byte_valid && !px_reset) begin
      for (int l = 0; l < `HISPI_LANES; l++) begin
        acc[l] <= acc_next[l];  // bits above fill are stale and never read
      end
    end
    if (byte_valid && emit) begin
      word_data <= word_next;
    end
  end

  // ----------------------------------------
  // fill count and strobe
  // ----------------------------------------
  always_ff @(posedge clk_out_pix or negedge idelay_rdy) begin
    if (!idelay_rdy) begin
      fill       <= '0;
      word_valid <= 1'b0;
    end else if (px_reset) begin
      fill       <= '0;  // bytes during reset are dropped
      word_valid <= 1'b0;
    end else begin
      word_valid <= byte_valid && emit;  // one word per byte at most
      if (byte_valid) begin
        fill <= fill_next;   // 8,16>6,14>4,12>2,10>0: four words per five bytes
      end
    end
  end

endmodule

/* rtl/sync_aligner.sv */
// finds word phase on lane 0 only, all lanes are assumed skew free
// a code word of all zeros would look like part of the run; payload needs a one bit
`timescale 1ns/1ps
`include "hispi_cfg.svh"

module sync_aligner
  import hispi_pkg::*;
(
  input  logic        clk_out_pix,
  input  logic        idelay_rdy,
  input  logic        px_reset,
  input  logic        word_valid,
  input  lane_words_t word_data,
  output lane_words_t pix_data,
  output logic        line_valid,
  output sync_flags_t sync_flags,
  output logic [9:0]  sync_word
);

  localparam int PIX_W = `HISPI_PIX_W;
  localparam int WIN_W = `HISPI_WIN_WORDS * PIX_W;
  localparam int RUN_W = `HISPI_SYNC_ZEROS;
  localparam int PH_W  = $clog2(PIX_W);
  // window bit 0 is the oldest bit; aligned word n starts at OFS + phase + 10n
  localparam int OFS       = 1;
  localparam int CODE_BASE = OFS + (`HISPI_WIN_WORDS - 2) * PIX_W;  // newest full word
  localparam int RUN_BASE  = CODE_BASE + PIX_W - RUN_W;             // one strobe before decode

  logic [WIN_W-1:0] win [`HISPI_LANES];  // last 50 bits per lane, time ordered
  logic             detect;              // zero run seen in lane 0
  logic [PH_W-1:0]  phase;
  logic             det_reg;             // decode pending on next strobe
  logic [PH_W-1:0]  phase_reg;
  logic [3:0]       valid_hist;          // line open over the last four words
  logic             strobe_q;            // window moved last clock
  sync_word_u       code_word;

  // first received bit of a word goes to the lower window index
  function automatic logic [PIX_W-1:0] rev_word(input logic [PIX_W-1:0] w);
    logic [PIX_W-1:0] r;
    for (int k = 0; k < PIX_W; k++) begin
      r[k] = w[PIX_W-1-k];
    end
    return r;
  endfunction

  // ----------------------------------------
  // per-lane window
  // ----------------------------------------
  always_ff @(posedge clk_out_pix or negedge idelay_rdy) begin
    if (!idelay_rdy) begin
      for (int l = 0; l < `HISPI_LANES; l++) win[l] <= '1;  // ones never match a run
    end else if (px_reset) begin
      for (int l = 0; l < `HISPI_LANES; l++) win[l] <= '1;
    end else if (word_valid) begin
      for (int l = 0; l < `HISPI_LANES; l++) begin
        win[l] <= {rev_word(word_data.lane[l]), win[l][WIN_W-1:PIX_W]};
      end
    end
  end

  // phase search, smallest phase = oldest run, which the 3FF word bounds
  always_comb begin
    detect = 1'b0;
    phase  = '0;
    for (int ph = PIX_W - 1; ph >= 0; ph--) begin
      if (win[0][RUN_BASE + ph +: RUN_W] == '0) begin
        detect = 1'b1;
        phase  = PH_W'(ph);
      end
    end
  end

  // code word sits right behind the run once the window has moved once more
  assign code_word.raw = rev_word(PIX_W'(win[0] >> (CODE_BASE + int'(phase_reg))));

  // ----------------------------------------
  // decode and line tracking
  // ----------------------------------------
  always_ff @(posedge clk_out_pix or negedge idelay_rdy) begin
    if (!idelay_rdy) begin
      det_reg    <= 1'b0;
      phase_reg  <= '0;
      valid_hist <= '0;
      strobe_q   <= 1'b0;
      sync_flags <= '0;
    end else if (px_reset) begin
      det_reg    <= 1'b0;
      phase_reg  <= '0;
      valid_hist <= '0;
      strobe_q   <= 1'b0;
      sync_flags <= '0;
    end else begin
      sync_flags <= '0;         // pulses only
      strobe_q   <= word_valid;
      if (word_valid) begin
        det_reg <= detect && !det_reg;  // run still visible one word later, skip it
        if (detect && !det_reg) phase_reg <= phase;
        if (det_reg) begin
          unique case (code_word.fld.code)
            CODE_SOF: begin
              sync_flags.sof <= 1'b1;
              valid_hist     <= 4'b0001;  // payload is the next word in
            end
            CODE_SOL: begin
              sync_flags.sol <= 1'b1;
              valid_hist     <= 4'b0001;
            end
            CODE_EOL: begin
              sync_flags.eol <= 1'b1;
              valid_hist     <= '0;
            end
            CODE_EOF: begin
              sync_flags.eof <= 1'b1;
              valid_hist     <= '0;
            end
            default: begin
              sync_flags.error <= 1'b1;  // bad code, wait for next SOF or SOL
              valid_hist       <= '0;
            end
          endcase
        end else begin
          valid_hist <= {valid_hist[2:0], valid_hist[0]};
        end
      end
    end
  end

  // debug copy of the last decoded code word
  always_ff @(posedge clk_out_pix) begin
    if (word_valid && det_reg) sync_word <= code_word.raw;
  end

  // ----------------------------------------
  // pixel output
  // ----------------------------------------
  always_comb begin
    for (int l = 0; l < `HISPI_LANES; l++) begin
      pix_data.lane[l] = rev_word(PIX_W'(win[l] >> (OFS + int'(phase_reg))));  // oldest word
    end
  end

  // header words reach the oldest slot while det_reg is up, mask them
  assign line_valid = strobe_q && (&valid_hist) && !det_reg;

endmodule

/* rtl/hispi_phy_top.sv */
// HiSPi pixel receiver, bytes come in already deserialized on clk_out_pix
// Packetized-SP, 10-bit pixels only; no back-pressure on any path
`timescale 1ns/1ps

module hispi_phy_top
  import hispi_pkg::*;
(
  input  logic        clk_out_pix,
  input  logic        idelay_rdy,      // async reset, active low
  input  logic        byte_valid,
  input  lane_bytes_t byte_data,
  output lane_words_t pix_data,        // four pixels per line_valid
  output logic        line_valid,
  output sync_flags_t sync_flags,
  output logic [9:0]  sync_word,       // last code word, for debug
  output logic        reset_sync_out
);

  logic        px_reset;
  logic        word_valid;
  lane_words_t word_data;

  // ----------------------------------------
  // reset sequencing
  // ----------------------------------------
  phy_reset_seq u_reset_seq (
    .clk_out_pix    (clk_out_pix),
    .idelay_rdy     (idelay_rdy),
    .px_reset       (px_reset),
    .reset_sync_out (reset_sync_out)
  );

  // ----------------------------------------
  // 8:10 repack
  // ----------------------------------------
  gearbox_8to10 u_gearbox (
    .clk_out_pix (clk_out_pix),
    .idelay_rdy  (idelay_rdy),
    .px_reset    (px_reset),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data),
    .word_valid  (word_valid),
    .word_data   (word_data)
  );

  // ----------------------------------------
  // phase search and sync decode
  // ----------------------------------------
  sync_aligner u_aligner (
    .clk_out_pix (clk_out_pix),
    .idelay_rdy  (idelay_rdy),
    .px_reset    (px_reset),
    .word_valid  (word_valid),
    .word_data   (word_data),
    .pix_data    (pix_data),
    .line_valid  (line_valid),
    .sync_flags  (sync_flags),
    .sync_word   (sync_word)
  );

endmodule

/* dv/hispi_model.svh */
// stream generator and expected-event queues, included in the testbench module body
// all lanes share one bit clock, so each queue entry holds one bit of every lane
`ifndef HISPI_MODEL_SVH
`define HISPI_MODEL_SVH

localparam int K_PIX   = 0;  // one line_valid word
localparam int K_SOF   = 1;
localparam int K_SOL   = 2;
localparam int K_EOL   = 3;
localparam int K_EOF   = 4;
localparam int K_ERR   = 5;
localparam int K_MULTI = 6;  // more than one flag in a cycle, never expected

logic [`HISPI_LANES-1:0] bitq [$];   // serialized bits not yet sent, oldest first
int                      exp_kind [$];
logic [63:0]             exp_data [$];  // pixel word, or code word for a flag
logic                    line_open = 1'b0;  // body words count as payload

// bit 5 forced, so no run of twenty zeros outside a header
function automatic logic [9:0] safe_word();
  return 10'(next_rand()) | 10'h020;
endfunction

function automatic int code_kind(input logic [2:0] code);
  case (code)
    3'b011:  return K_SOF;
    3'b001:  return K_SOL;
    3'b101:  return K_EOL;
    3'b111:  return K_EOF;
    default: return K_ERR;
  endcase
endfunction

task automatic expect_event(input int kind, input logic [63:0] data);
  exp_kind.push_back(kind);
  exp_data.push_back(data);
endtask

// ----------------------------------------
// serializer
// ----------------------------------------
task automatic push_word(input lane_words_t w);
  logic [`HISPI_LANES-1:0] col;
  for (int b = `HISPI_PIX_W - 1; b >= 0; b--) begin  // bit 9 goes out first
    for (int l = 0; l < `HISPI_LANES; l++) begin
      col[l] = w.lane[l][b];
    end
    bitq.push_back(col);
  end
endtask

task automatic push_same(input logic [9:0] v);
  lane_words_t w;
  for (int l = 0; l < `HISPI_LANES; l++) begin
    w.lane[l] = v;
  end
  push_word(w);
endtask

// ones only, shifts the word phase
task automatic push_junk(input int n);
  repeat (n) bitq.push_back('1);
endtask

// ----------------------------------------
// stream items
// ----------------------------------------
task automatic push_header(input logic [2:0] code);
  logic [9:0] cw;
  cw      = safe_word();
  cw[2:0] = code;
  push_same(10'h3ff);
  push_same(10'h000);
  push_same(10'h000);
  push_same(cw);
  expect_event(code_kind(code), 64'(cw));
  line_open = (code == 3'b011) || (code == 3'b001);  // only SOF and SOL open a line
endtask

// payload inside an open line, filler otherwise
task automatic push_body(input int n);
  lane_words_t w;
  repeat (n) begin
    for (int l = 0; l < `HISPI_LANES; l++) begin
      w.lane[l] = safe_word();
    end
    push_word(w);
    if (line_open) expect_event(K_PIX, 64'(w));
  end
endtask

`endif

/* dv/tb_hispi_phy.sv */
// random Packetized-SP streams from a fixed seed, checked event by event against a model
// every lane carries the same headers; bytes arrive with random idle gaps
`timescale 1ns/1ps
`include "hispi_cfg.svh"

module tb_hispi_phy
  import hispi_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RST_CYCLES   = 4;
  localparam int DRAIN_CYCLES = 60;   // DUT stalls once bytes stop
  localparam int WD_SLACK     = 400;  // cycles for reset and drains

  logic        clk_out_pix;
  logic        idelay_rdy;
  logic        byte_valid;
  lane_bytes_t byte_data;
  lane_words_t pix_data;
  logic        line_valid;
  sync_flags_t sync_flags;
  logic [9:0]  sync_word;
  logic        reset_sync_out;

  logic [31:0] rng = 32'd57;  // xorshift state
  string       cur_test;
  int          err_count   = 0;
  int          check_count = 0;
  int          test_count  = 0;
  int          event_count = 0;
  int          total_bytes = 0;
  int          err_start;
  int          ev_start;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int rand_range(input int n);
    return int'(next_rand() % 32'(n));
  endfunction

  `include "hispi_model.svh"

  hispi_phy_top hispi_phy_top_i (
    .clk_out_pix    (clk_out_pix),
    .idelay_rdy     (idelay_rdy),
    .byte_valid     (byte_valid),
    .byte_data      (byte_data),
    .pix_data       (pix_data),
    .line_valid     (line_valid),
    .sync_flags     (sync_flags),
    .sync_word      (sync_word),
    .reset_sync_out (reset_sync_out)
  );

  initial begin
    clk_out_pix = 1'b0;
    forever #(CLK_PERIOD / 2) clk_out_pix = ~clk_out_pix;
  end

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
    end
  endtask

  // ----------------------------------------
  // output monitor
  // ----------------------------------------
  function automatic int flag_kind(input sync_flags_t f);
    if ($countones(f) != 1) return K_MULTI;
    if (f.sof) return K_SOF;
    if (f.sol) return K_SOL;
    if (f.eol) return K_EOL;
    if (f.eof) return K_EOF;
    return K_ERR;
  endfunction

  task automatic take_event(input int kind, input logic [63:0] data);
    int          ek;
    logic [63:0] ed;
    string       what;
    if (exp_kind.size() == 0) begin
      err_count++;
      $display("Error: %s saw an output of kind %0d while nothing was expected", cur_test, kind);
    end else begin
      ek = exp_kind.pop_front();
      ed = exp_data.pop_front();
      event_count++;
      check_value("event kind", 64'(ek), 64'(kind));
      if (ek == K_PIX) what = "pix_data";
      else what = "sync_word";
      check_value(what, ed, data);
    end
  endtask

  always @(negedge clk_out_pix) begin  // outputs settled half a cycle after the edge
    if (|sync_flags) take_event(flag_kind(sync_flags), 64'(sync_word));
    if (line_valid) take_event(K_PIX, 64'(pix_data));
  end

  // ----------------------------------------
  // byte driver and test flow
  // ----------------------------------------
  task automatic send_stream();
    lane_bytes_t             b;
    logic [`HISPI_LANES-1:0] col;
    int                      gap;
    total_bytes += bitq.size() / `HISPI_BYTE_W;  // leftover bits wait for the next stream
    while (bitq.size() >= `HISPI_BYTE_W) begin
      gap = rand_range(3);
      repeat (gap) begin
        @(posedge clk_out_pix);
        byte_valid <= 1'b0;
      end
      for (int k = 0; k < `HISPI_BYTE_W; k++) begin
        col = bitq.pop_front();
        for (int l = 0; l < `HISPI_LANES; l++) begin
          b.lane[l][`HISPI_BYTE_W-1-k] = col[l];  // first bit in bit 7
        end
      end
      @(posedge clk_out_pix);
      byte_valid <= 1'b1;
      byte_data  <= b;
    end
    @(posedge clk_out_pix);
    byte_valid <= 1'b0;
  endtask

  task automatic drain_events();
    int waited;
    waited = 0;
    while (exp_kind.size() != 0 && waited < DRAIN_CYCLES) begin
      @(posedge clk_out_pix);
      waited++;
    end
    if (exp_kind.size() != 0) begin
      err_count++;
      $display("Error: %s ended with %0d expected outputs that never appeared",
               cur_test, exp_kind.size());
      exp_kind.delete();
      exp_data.delete();
    end
    repeat (4) @(posedge clk_out_pix);  // stray outputs still land in this test
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    err_start = err_count;
    ev_start  = event_count;
    test_count++;
  endtask

  task automatic end_test();
    $display("%-14s %0d outputs, %0d errors", cur_test, event_count - ev_start,
             err_count - err_start);
  endtask

  task automatic check_quiet();
    check_value("reset_sync_out", 64'(1), 64'(reset_sync_out));
    check_value("line_valid", 64'(0), 64'(line_valid));
    check_value("sync_flags", 64'(0), 64'(sync_flags));
  endtask

  task automatic reset_test();
    logic [31:0] r;
    begin_test("reset");
    repeat (RST_CYCLES) begin
      @(negedge clk_out_pix);
      check_quiet();
    end
    @(posedge clk_out_pix);
    idelay_rdy <= 1'b1;
    for (int i = 0; i < `HISPI_RST_HOLD + 2; i++) begin
      @(negedge clk_out_pix);
      check_quiet();
      @(posedge clk_out_pix);
      r = next_rand();
      byte_valid <= r[0] && (i < `HISPI_RST_HOLD);  // junk bytes the DUT must drop
      byte_data  <= lane_bytes_t'(next_rand());
    end
    @(negedge clk_out_pix);
    check_value("reset_sync_out", 64'(0), 64'(reset_sync_out));
    end_test();
  endtask

  // one frame at a fresh phase, SOF then zero to two extra lines, then EOF
  task automatic random_run();
    int lines;
    push_junk(rand_range(10));
    push_body(1 + rand_range(3));
    push_header(3'b011);
    push_body(2 + rand_range(7));
    lines = rand_range(3);
    repeat (lines) begin
      push_header(3'b101);
      push_body(1 + rand_range(3));
      push_header(3'b001);
      push_body(2 + rand_range(7));
    end
    push_header(3'b111);
    push_body(8);   // flushes the window
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  function automatic longint wd_limit_ns();
    return (longint'(total_bytes) * 4 * 3 + WD_SLACK) * CLK_PERIOD;
  endfunction

  initial begin
    @(posedge clk_out_pix);
    while ($time <= wd_limit_ns()) @(posedge clk_out_pix);
    $display("Error: watchdog expired at %0t, the DUT stopped producing expected output", $time);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    idelay_rdy = 1'b0;
    byte_valid = 1'b0;
    byte_data  = '0;
    reset_test();

    begin_test("sof_frame");
    push_junk(rand_range(10));
    push_body(2);
    push_header(3'b011);
    push_body(12);
    push_header(3'b111);
    push_body(8);
    send_stream();
    drain_events();
    end_test();

    begin_test("sol_eol_seq");
    push_junk(rand_range(10));
    push_body(2);
    push_header(3'b001);
    push_body(6);
    push_header(3'b101);
    push_body(4);   // closed line, no pixels
    push_header(3'b001);
    push_body(5);
    push_header(3'b111);
    push_body(8);
    send_stream();
    drain_events();
    end_test();

    begin_test("bad_code");
    push_junk(rand_range(10));
    push_body(2);
    push_header(3'b011);
    push_body(4);
    push_header(3'b010);  // error closes the line
    push_body(5);
    push_header(3'b001);
    push_body(4);
    push_header(3'b111);
    push_body(8);
    send_stream();
    drain_events();
    end_test();

    begin_test("random_phase");
    repeat (20) begin
      random_run();
      send_stream();
      drain_events();
    end
    end_test();

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+rtl
+incdir+dv
rtl/hispi_pkg.sv
rtl/phy_reset_seq.sv
rtl/gearbox_8to10.sv
rtl/sync_aligner.sv
rtl/hispi_phy_top.sv
dv/tb_hispi_phy.sv

/* Makefile */
# Verilator build and run for the HiSPi receiver testbench

VERILATOR ?= verilator
TOP       ?= tb_hispi_phy
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh dv/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the simulator exits cleanly and prints the pass message
run: $(SIM)
	@out="$$(./$(SIM))"; status=$$?; echo "$$out"; \
	test $$status -eq 0 && echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
